// File: rtl/read_fifo_pkg.sv
// shared widths, depth and vector types for the DDR3 PHY read-data FIFO
// one entry is a rising DQ beat with its falling partner packed above it
package read_fifo_pkg;

	// number of DQ bits sampled on each strobe edge
	localparam int DQ_WIDTH = 8;

	// a FIFO entry holds two beats, falling beat in the upper half
	// and rising beat in the lower half
	localparam int WORD_WIDTH = 2 * DQ_WIDTH;

	// number of flop entries in the storage bank
	// read-latency calibration keeps the write and read pointers
	// no further apart than this
	localparam int FIFO_DEPTH = 8;

	// pointer width follows from the depth
	// both pointers wrap naturally only when the depth is a power of two,
	// the pointer logic still compares against FIFO_DEPTH - 1 so that
	// a different depth keeps working
	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

	// one DQ beat as captured on a single strobe edge
	typedef logic [DQ_WIDTH-1:0] dq_t;

	// one packed FIFO word, {falling beat, rising beat}
	typedef logic [WORD_WIDTH-1:0] word_t;

	// a write or read pointer into the flop bank
	typedef logic [ADDR_WIDTH-1:0] fifo_addr_t;

	// notes on the clock domains that use these types
	//
	// dq_t only lives in the capture domain, where the beats arrive
	// from the strobe-aligned capture registers
	//
	// word_t crosses from the capture domain into the controller
	// domain through the flop bank, the reader never samples an entry
	// sooner than three controller cycles after it was written
	//
	// fifo_addr_t is used on both sides, but each pointer stays in
	// its own domain and is never synchronized across
	//
	// there are no full or empty flags, the distance between the two
	// pointers is owned by calibration outside this block

endpackage

// File: rtl/capture_write.sv
// capture side of the read-data FIFO, runs on the strobe-derived wr_clk
// packs one rising and one falling DQ beat into a word and hands it to the
// flop bank together with a one-cycle write strobe and a wrapping address
`timescale 1ns/1ps

module capture_write (
	input  logic                      wr_clk,
	input  logic                      wr_reset_n,
	input  logic                      capture_valid,
	input  read_fifo_pkg::dq_t        dq_rise,
	input  read_fifo_pkg::dq_t        dq_fall,
	output logic                      mem_wr_en,
	output read_fifo_pkg::fifo_addr_t mem_wr_addr,
	output read_fifo_pkg::word_t      mem_wr_data
);

	// pointer to the entry that the next captured word goes into
	read_fifo_pkg::fifo_addr_t wr_ptr;

	// pointer value after this capture, wrapping at the last entry
	read_fifo_pkg::fifo_addr_t wr_ptr_next;

	// the pointer wraps explicitly so the depth does not have to be
	// a power of two
	always_comb begin
		if (wr_ptr == read_fifo_pkg::fifo_addr_t'(read_fifo_pkg::FIFO_DEPTH - 1)) begin
			wr_ptr_next = '0;
		end else begin
			wr_ptr_next = wr_ptr + 1'b1;
		end
	end

	// write pointer, advances on the same edge that captures the beats
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			wr_ptr <= '0;
		end else if (capture_valid) begin
			wr_ptr <= wr_ptr_next;
		end
	end

	// the write strobe follows capture_valid by one cycle, so one
	// strobe goes out for every beat pair that was flagged valid
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			mem_wr_en <= 1'b0;
		end else begin
			mem_wr_en <= capture_valid;
		end
	end

	// address and data are latched together with the strobe
	// the address is the pointer before it advanced, so the first word
	// after reset lands in entry 0
	// the falling beat sits above the rising beat in the packed word
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			mem_wr_addr <= '0;
			mem_wr_data <= '0;
		end else if (capture_valid) begin
			mem_wr_addr <= wr_ptr;
			mem_wr_data <= {dq_fall, dq_rise};
		end
	end

	// address and data hold their last value between captures,
	// the flop bank only looks at them while mem_wr_en is high

endmodule

// File: rtl/flop_mem.sv
// dual-clock flop storage for the read-data FIFO
// entries are written in wr_clk and selected by rd_addr through a plain
// index multiplexer, the selected word is registered on every rd_clk edge
`timescale 1ns/1ps

module flop_mem (
	input  logic                      wr_clk,
	input  logic                      wr_reset_n,
	input  logic                      wr_en,
	input  read_fifo_pkg::fifo_addr_t wr_addr,
	input  read_fifo_pkg::word_t      wr_data,
	input  logic                      rd_clk,
	input  logic                      rd_reset_n,
	input  read_fifo_pkg::fifo_addr_t rd_addr,
	output read_fifo_pkg::word_t      rd_data
);

	// every entry is visible at once so the read side can pick any
	// of them without going through a RAM port
	wire read_fifo_pkg::word_t all_entries [read_fifo_pkg::FIFO_DEPTH];

	// word chosen by the current read address, before the read register
	read_fifo_pkg::word_t mux_data;

	// one register per entry, each with its own write enable
	// only the entry whose index matches wr_addr loads on a write,
	// all other entries keep their contents
	for (genvar entry = 0; entry < read_fifo_pkg::FIFO_DEPTH; entry++) begin : mem_location

		// this entry is the target of the current write
		logic entry_sel;

		// stored word of this entry
		read_fifo_pkg::word_t entry_q;

		assign entry_sel = wr_en &&
			(wr_addr == read_fifo_pkg::fifo_addr_t'(entry));

		always_ff @(posedge wr_clk or negedge wr_reset_n) begin
			if (!wr_reset_n) begin
				entry_q <= '0;
			end else if (entry_sel) begin
				entry_q <= wr_data;
			end
		end

		assign all_entries[entry] = entry_q;

	end

	// read multiplexer
	// rd_addr comes from the controller domain while the entries change
	// in the capture domain, the selected entry is stable by the time it
	// is sampled because reads trail writes by at least three rd_clk
	// cycles
	assign mux_data = all_entries[rd_addr];

	// read register, loads unconditionally on every rd_clk edge
	// the read side decides separately which cycles carry a valid word
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= mux_data;
		end
	end

	// after reset every entry reads back as zero, so a read issued
	// before any capture returns an all-zero word
	//
	// there is no protection against overwriting an unread entry or
	// reading an entry that was never written, the pointer distance set
	// by calibration is what keeps the data coherent
	//
	// the write side resets on wr_reset_n and the read register on
	// rd_reset_n, both come from the same reset source in the PHY but
	// are released in their own clock domains

endmodule

// File: rtl/read_sequencer.sv
// read side of the read-data FIFO, runs on the controller clock rd_clk
// steps the read pointer on every rd_en pulse and produces the valid
// strobe that lines up with the word the flop bank has just registered
`timescale 1ns/1ps

module read_sequencer (
	input  logic                      rd_clk,
	input  logic                      rd_reset_n,
	input  logic                      rd_en,
	output read_fifo_pkg::fifo_addr_t mem_rd_addr,
	output logic                      afi_rdata_valid
);

	// pointer to the entry that the next rd_en returns
	read_fifo_pkg::fifo_addr_t rd_ptr;

	// pointer value after this read, wrapping at the last entry
	read_fifo_pkg::fifo_addr_t rd_ptr_next;

	// rd_en delayed by one rd_clk cycle
	logic rd_en_q;

	// same wrap rule as the write pointer, so both sides agree on the
	// entry order even when the depth is not a power of two
	always_comb begin
		if (rd_ptr == read_fifo_pkg::fifo_addr_t'(read_fifo_pkg::FIFO_DEPTH - 1)) begin
			rd_ptr_next = '0;
		end else begin
			rd_ptr_next = rd_ptr + 1'b1;
		end
	end

	// the read pointer feeds the flop bank multiplexer directly
	// on the edge where rd_en is high the read register still sees the
	// old pointer and loads that entry, while the pointer itself moves on
	// to the next entry at the same edge
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_ptr <= '0;
		end else if (rd_en) begin
			rd_ptr <= rd_ptr_next;
		end
	end

	// valid pipeline, one stage deep
	// the word loaded on the rd_en edge appears at the read register
	// output for the following cycle, and so does this delayed strobe
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_en_q <= 1'b0;
		end else begin
			rd_en_q <= rd_en;
		end
	end

	assign mem_rd_addr = rd_ptr;

	// back-to-back rd_en pulses give back-to-back valid cycles, since
	// the pointer steps once per pulse and the read register loads on
	// every edge
	assign afi_rdata_valid = rd_en_q;

	// read latency is therefore exactly one rd_clk cycle from rd_en to
	// afi_rdata_valid
	//
	// the sequencer does not know how many words are waiting, so a
	// read issued too early returns whatever the entry held before,
	// which is zero right after reset
	//
	// nothing here crosses into the capture domain, the write pointer
	// is never compared against the read pointer

endmodule

// File: rtl/read_datapath.sv
// top level of the DDR3 PHY read-data FIFO
// moves captured DQ words from the strobe domain wr_clk into the controller
// domain rd_clk through a flop bank, with a fixed one-cycle read latency
`timescale 1ns/1ps

module read_datapath (
	input  logic                 wr_clk,
	input  logic                 wr_reset_n,
	input  logic                 capture_valid,
	input  read_fifo_pkg::dq_t   dq_rise,
	input  read_fifo_pkg::dq_t   dq_fall,
	input  logic                 rd_clk,
	input  logic                 rd_reset_n,
	input  logic                 rd_en,
	output read_fifo_pkg::word_t afi_rdata,
	output logic                 afi_rdata_valid
);

	// write strobe, address and packed word from the capture side,
	// all registered in wr_clk
	logic                      mem_wr_en;
	read_fifo_pkg::fifo_addr_t mem_wr_addr;
	read_fifo_pkg::word_t      mem_wr_data;

	// current read pointer from the sequencer, in rd_clk
	read_fifo_pkg::fifo_addr_t mem_rd_addr;

	// capture side
	// one word per wr_clk edge with capture_valid high
	capture_write capture_write_i (
		.wr_clk        (wr_clk),
		.wr_reset_n    (wr_reset_n),
		.capture_valid (capture_valid),
		.dq_rise       (dq_rise),
		.dq_fall       (dq_fall),
		.mem_wr_en     (mem_wr_en),
		.mem_wr_addr   (mem_wr_addr),
		.mem_wr_data   (mem_wr_data)
	);

	// storage bank, written in wr_clk and read in rd_clk
	// its read register output is the word handed to the controller
	flop_mem flop_mem_i (
		.wr_clk     (wr_clk),
		.wr_reset_n (wr_reset_n),
		.wr_en      (mem_wr_en),
		.wr_addr    (mem_wr_addr),
		.wr_data    (mem_wr_data),
		.rd_clk     (rd_clk),
		.rd_reset_n (rd_reset_n),
		.rd_addr    (mem_rd_addr),
		.rd_data    (afi_rdata)
	);

	// read side
	// advances the read pointer and marks the cycle after each rd_en
	read_sequencer read_sequencer_i (
		.rd_clk          (rd_clk),
		.rd_reset_n      (rd_reset_n),
		.rd_en           (rd_en),
		.mem_rd_addr     (mem_rd_addr),
		.afi_rdata_valid (afi_rdata_valid)
	);

	// afi_rdata is only meaningful while afi_rdata_valid is high,
	// in all other cycles it shows whatever entry the pointer selects
	//
	// the caller keeps reads at least three rd_clk cycles behind the
	// matching capture and never lets more than FIFO_DEPTH words pile up

endmodule

// File: bench/tb_clocks.sv
// clock and reset source for the read-data FIFO testbench
// makes rd_clk, a 25 ns delayed wr_clk of the same period and both resets
`timescale 1ns/1ps

module tb_clocks (
	input  logic reset_req,
	output logic rd_clk,
	output logic wr_clk,
	output logic rd_reset_n,
	output logic wr_reset_n
);

	// both clocks run at 100 ns
	localparam int HALF_PERIOD_NS = 50;
	// the strobe domain trails the controller clock by a quarter period
	localparam int WR_SHIFT_NS = 25;
	localparam int RESET_CYCLES = 8;

	initial begin
		rd_clk = 1'b0;
		forever #(HALF_PERIOD_NS) rd_clk = ~rd_clk;
	end

	initial begin
		wr_clk = 1'b0;
		#(WR_SHIFT_NS);
		forever #(HALF_PERIOD_NS) wr_clk = ~wr_clk;
	end

	// both resets drop together at time zero and again whenever reset_req
	// rises, and are released 5 ns after the eighth rd_clk edge
	// the release lands between edges of either clock
	initial begin
		rd_reset_n = 1'b0;
		wr_reset_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge rd_clk);
			#5;
			rd_reset_n = 1'b1;
			wr_reset_n = 1'b1;
			@(posedge reset_req);
			rd_reset_n = 1'b0;
			wr_reset_n = 1'b0;
		end
	end

endmodule

// File: bench/read_datapath_tb.sv
// testbench for the DDR3 PHY read-data FIFO
// captures random DQ beat pairs in wr_clk, reads them back in rd_clk and
// checks data order and valid timing against a queue of packed words
`timescale 1ns/1ps

module read_datapath_tb;

	localparam int CLK_PERIOD_NS = 100;
	localparam int DRIVE_DELAY_NS = 5;
	// a word is captured on the edge that follows its drive time
	localparam int EDGE_AHEAD_NS = CLK_PERIOD_NS - DRIVE_DELAY_NS;
	// earliest read of a word, counted from the edge that captured it
	localparam int MIN_LAG_NS = 3 * CLK_PERIOD_NS;
	// the wrap test keeps reads four cycles behind the writes
	localparam int WRAP_LAG_NS = 4 * CLK_PERIOD_NS;

	// cycle budget of each test, reset pulses included
	localparam int RESET_STATE_CYCLES = 20;
	localparam int BURST_CYCLES = 20;
	localparam int WRAP_CYCLES = 30;
	localparam int GAP_CYCLES = 100;
	localparam int MIDRUN_CYCLES = 50;
	localparam int TEST_CYCLES = RESET_STATE_CYCLES + BURST_CYCLES + WRAP_CYCLES +
		GAP_CYCLES + MIDRUN_CYCLES;
	localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD_NS;

	logic                 rd_clk;
	logic                 wr_clk;
	logic                 rd_reset_n;
	logic                 wr_reset_n;
	logic                 reset_req;
	logic                 capture_valid;
	read_fifo_pkg::dq_t   dq_rise;
	read_fifo_pkg::dq_t   dq_fall;
	logic                 rd_en;
	read_fifo_pkg::word_t afi_rdata;
	logic                 afi_rdata_valid;

	integer seed;
	string  test_name;

	// words captured whose read has not been issued yet, oldest first
	read_fifo_pkg::word_t model_q[$];
	// time of the wr_clk edge that captured each word in model_q
	realtime              capt_q[$];
	// words owed by reads already issued, in the order they must return
	read_fifo_pkg::word_t expect_q[$];
	read_fifo_pkg::word_t expected_word;

	tb_clocks clocks_i (
		.reset_req  (reset_req),
		.rd_clk     (rd_clk),
		.wr_clk     (wr_clk),
		.rd_reset_n (rd_reset_n),
		.wr_reset_n (wr_reset_n)
	);

	read_datapath dut_i (
		.wr_clk          (wr_clk),
		.wr_reset_n      (wr_reset_n),
		.capture_valid   (capture_valid),
		.dq_rise         (dq_rise),
		.dq_fall         (dq_fall),
		.rd_clk          (rd_clk),
		.rd_reset_n      (rd_reset_n),
		.rd_en           (rd_en),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// read latency is one rd_clk cycle in both directions
	valid_after_rd_en: assert property (
		@(posedge rd_clk) disable iff (!rd_reset_n) rd_en |=> afi_rdata_valid
	) else report_failure($sformatf("MISMATCH %s afi_rdata_valid expected 1 actual 0",
		test_name));

	valid_only_after_rd_en: assert property (
		@(posedge rd_clk) disable iff (!rd_reset_n) !rd_en |=> !afi_rdata_valid
	) else report_failure($sformatf("MISMATCH %s afi_rdata_valid expected 0 actual 1",
		test_name));

	// outputs move on the rising edge, so the falling edge sees them settled
	always @(negedge rd_clk) begin
		if (!rd_reset_n) begin
			assert (afi_rdata_valid === 1'b0)
			else report_failure($sformatf("MISMATCH %s afi_rdata_valid in reset expected 0 actual %b",
				test_name, afi_rdata_valid));
		end else if (afi_rdata_valid) begin
			if (expect_q.size() == 0) begin
				report_failure($sformatf("%s: afi_rdata_valid high with no read outstanding",
					test_name));
			end else begin
				expected_word = expect_q.pop_front();
				assert (afi_rdata === expected_word)
				else report_failure($sformatf("MISMATCH %s afi_rdata expected %h actual %h",
					test_name, expected_word, afi_rdata));
			end
		end
	end

	// captures count words, optionally idling on random cycles
	// never lets more than FIFO_DEPTH words stand unread
	task automatic write_words(input int count, input bit random_gaps);
		int     written;
		integer rnd;
		bit     want;
		written = 0;
		while (written < count) begin
			@(posedge wr_clk);
			#(DRIVE_DELAY_NS);
			rnd = $random(seed);
			want = random_gaps ? rnd[0] : 1'b1;
			if (want && model_q.size() < read_fifo_pkg::FIFO_DEPTH) begin
				rnd = $random(seed);
				dq_rise = rnd[read_fifo_pkg::DQ_WIDTH-1:0];
				rnd = $random(seed);
				dq_fall = rnd[read_fifo_pkg::DQ_WIDTH-1:0];
				capture_valid = 1'b1;
				// falling beat sits above the rising beat
				model_q.push_back({dq_fall, dq_rise});
				capt_q.push_back($realtime + EDGE_AHEAD_NS);
				written++;
			end else begin
				capture_valid = 1'b0;
			end
		end
		@(posedge wr_clk);
		#(DRIVE_DELAY_NS);
		capture_valid = 1'b0;
	endtask

	// issues count reads, each one only once its word is lag_ns old
	task automatic read_words(input int count, input int lag_ns, input bit random_gaps);
		int     issued;
		integer rnd;
		bit     ready;
		issued = 0;
		while (issued < count) begin
			@(posedge rd_clk);
			#(DRIVE_DELAY_NS);
			rnd = $random(seed);
			ready = 1'b0;
			if (model_q.size() > 0) begin
				if (capt_q[0] + lag_ns <= $realtime + EDGE_AHEAD_NS) begin
					ready = random_gaps ? rnd[0] : 1'b1;
				end
			end
			if (ready) begin
				expect_q.push_back(model_q.pop_front());
				void'(capt_q.pop_front());
				rd_en = 1'b1;
				issued++;
			end else begin
				rd_en = 1'b0;
			end
		end
		@(posedge rd_clk);
		#(DRIVE_DELAY_NS);
		rd_en = 1'b0;
	endtask

	// waits for the last read to return, then nothing may be owed
	task automatic check_drained();
		repeat (2) @(posedge rd_clk);
		if (expect_q.size() != 0) begin
			report_failure($sformatf("%s: %0d issued reads never returned data",
				test_name, expect_q.size()));
		end
	endtask

	// one read with nothing captured since reset, entry 0 still holds zero
	task automatic read_reset_word();
		@(posedge rd_clk);
		#(DRIVE_DELAY_NS);
		expect_q.push_back('0);
		rd_en = 1'b1;
		@(posedge rd_clk);
		#(DRIVE_DELAY_NS);
		rd_en = 1'b0;
		check_drained();
	endtask

	// asserts both resets, drops any unread words from the model and
	// returns once both domains are out of reset again
	task automatic pulse_resets();
		@(posedge rd_clk);
		#(DRIVE_DELAY_NS);
		reset_req = 1'b1;
		wait (rd_reset_n === 1'b0);
		model_q.delete();
		capt_q.delete();
		@(posedge rd_clk);
		#(DRIVE_DELAY_NS);
		reset_req = 1'b0;
		wait (rd_reset_n && wr_reset_n);
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_failure($sformatf("%s: watchdog expired after %0d ns", test_name, WATCHDOG_NS));
	end

	initial begin
		seed = 32'h82960410;
		reset_req = 1'b0;
		capture_valid = 1'b0;
		dq_rise = '0;
		dq_fall = '0;
		rd_en = 1'b0;

		// the negedge checker watches valid while reset is held
		test_name = "reset_state";
		wait (rd_reset_n && wr_reset_n);
		repeat (2) @(posedge rd_clk);
		read_reset_word();
		// the zero read moved only the read pointer, so realign both
		pulse_resets();

		test_name = "ordered_burst";
		write_words(5, 1'b0);
		read_words(5, MIN_LAG_NS, 1'b0);
		check_drained();

		// 20 words through 8 entries wraps both pointers twice
		test_name = "wrap_around";
		fork
			write_words(20, 1'b0);
			read_words(20, WRAP_LAG_NS, 1'b0);
		join
		check_drained();

		test_name = "gaps";
		fork
			write_words(24, 1'b1);
			read_words(24, MIN_LAG_NS, 1'b1);
		join
		check_drained();

		// three words are left unread when the resets hit
		test_name = "midrun_reset";
		write_words(3, 1'b0);
		repeat (3) @(posedge rd_clk);
		pulse_resets();
		read_reset_word();
		pulse_resets();
		fork
			write_words(6, 1'b0);
			read_words(6, MIN_LAG_NS, 1'b0);
		join
		check_drained();

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: all.f
rtl/read_fifo_pkg.sv
rtl/capture_write.sv
rtl/flop_mem.sv
rtl/read_sequencer.sv
rtl/read_datapath.sv
bench/tb_clocks.sv
bench/read_datapath_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the read-data FIFO testbench with Verilator, run it into sim.log
# and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module read_datapath_tb \
	-f all.f \
	-o read_datapath_sim \
	&& ./obj_dir/read_datapath_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"

grep -Fqx ">>> PASS" sim.log \
	&& echo "simulation passed" \
	&& exit 0 \
	|| echo "simulation failed, see sim.log"

exit 1
